//--- src.f
+incdir+include
logic/exe_pkg.sv
logic/exe_divider.sv
logic/exe_alu.sv
logic/exe_mem_req.sv
logic/exe_stage.sv
verification/exe_stage_tb.sv

//--- Bender.yml
package:
  name: exe_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/exe_pkg.sv
      - logic/exe_divider.sv
      - logic/exe_alu.sv
      - logic/exe_mem_req.sv
      - logic/exe_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/exe_stage_tb.sv

//--- include/exe_tb_consts.svh
`ifndef EXE_TB_CONSTS_SVH
`define EXE_TB_CONSTS_SVH

// clock period and reset length of the testbench
`define TB_HALF_PERIOD 5
`define TB_RESET_CYCLES 4

// fixed seed for the back-pressure model
`define TB_SEED 32'hcdcce145

// cycles allowed per table row, plus slack for reset
`define TB_CYCLES_PER_ROW 40
`define TB_CYCLE_SLACK 200

`endif

//--- verification/exe_stage_tb.sv
`timescale 1ns/1ps
`include "exe_consts.svh"
`include "exe_tb_consts.svh"

module exe_stage_tb;
    import exe_pkg::*;

    // operation index, same order as the fields of alu_op_t
    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_SLT = 2;
    localparam int OP_SLTU = 3;
    localparam int OP_NOR = 6;
    localparam int OP_SLL = 8;
    localparam int OP_SRL = 9;
    localparam int OP_SRA = 10;
    localparam int OP_LUI = 11;
    localparam int OP_MUL = 12;
    localparam int OP_MULH = 13;
    localparam int OP_MULHU = 14;
    localparam int OP_DIV = 15;
    localparam int OP_MOD = 16;
    localparam int OP_DIVU = 17;
    localparam int OP_MODU = 18;
    localparam word_t STORE_DATA = 32'ha1b2c3d4;
    localparam word_t PC_BASE = 32'h1c000000;

    typedef struct {
        string      name;
        int         op;
        word_t      src1;
        word_t      src2;
        st_op_t     st_op;
        ld_op_t     ld_op;
        logic       rdcntvh;
        logic       rdcntvl;
        logic [5:0] exc;
        logic       ms_ex;
        logic       wb_ex;
        word_t      result;
        logic [3:0] we;
        word_t      wdata;
        logic       ale;
    } row_t;

    logic                   clk;
    logic                   resetn;
    logic                   ds2es_valid;
    ds2es_bus_t             ds2es_bus;
    logic                   es_allowin;
    logic                   ms_allowin;
    logic                   es2ms_valid;
    es2ms_bus_t             es2ms_bus;
    es_fwd_t                es_fwd;
    logic                   data_sram_en;
    logic [3:0]             data_sram_we;
    word_t                  data_sram_addr;
    word_t                  data_sram_wdata;
    logic                   ms_ex;
    logic                   wb_ex;

    row_t                   rows[$];
    row_t                   r;
    int                     seed = `TB_SEED;
    int                     cycle_count = 0;
    int                     cycle_limit = 0;
    // cycle count at the moment resetn rose
    int                     release_cycle = 0;

    exe_stage i_exe_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ds2es_valid     (ds2es_valid),
        .ds2es_bus       (ds2es_bus),
        .es_allowin      (es_allowin),
        .ms_allowin      (ms_allowin),
        .es2ms_valid     (es2ms_valid),
        .es2ms_bus       (es2ms_bus),
        .es_fwd          (es_fwd),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .ms_ex           (ms_ex),
        .wb_ex           (wb_ex)
    );

    initial clk = 1'b0;
    always #(`TB_HALF_PERIOD) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the stage stopped making progress after %0d cycles", cycle_count);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic check(input string name, input string what,
                         input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    function automatic row_t blank_row(string name, int op, word_t a, word_t b, word_t res);
        row_t n;
        n = '{name: name, op: op, src1: a, src2: b, st_op: '0, ld_op: '0, rdcntvh: 1'b0,
              rdcntvl: 1'b0, exc: '0, ms_ex: 1'b0, wb_ex: 1'b0, result: res, we: '0,
              wdata: '0, ale: 1'b0};
        return n;
    endfunction

    task automatic alu_row(string name, int op, word_t a, word_t b, word_t res);
        rows.push_back(blank_row(name, op, a, b, res));
    endtask

    function automatic row_t store_entry(string name, st_op_t st, word_t addr, logic [3:0] we,
                                         word_t wdata, logic ale);
        row_t n;
        n = blank_row(name, OP_ADD, addr, 32'h0, addr);
        n.st_op = st;
        n.we = we;
        n.wdata = wdata;
        n.ale = ale;
        return n;
    endfunction

    task automatic store_row(string name, st_op_t st, word_t addr, logic [3:0] we,
                             word_t wdata, logic ale);
        rows.push_back(store_entry(name, st, addr, we, wdata, ale));
    endtask

    task automatic step_backpressure();
        int rnd;
        @(posedge clk);
        #1;
        rnd = $random(seed);
        ms_allowin = rnd[0];
        ms_ex = 1'b0;
        wb_ex = 1'b0;
    endtask

    // the stable counter reads zero in the cycle that resetn rose
    function automatic word_t expected_result(row_t x);
        logic [63:0] elapsed;
        elapsed = 64'(cycle_count - release_cycle);
        if (x.rdcntvh) begin
            return elapsed[63:32];
        end else if (x.rdcntvl) begin
            return elapsed[31:0];
        end
        return x.result;
    endfunction

    task automatic apply_row(int idx);
        ds2es_bus_t  bus;
        logic        is_div;
        int          cyc;
        int          first_rise;
        r = rows[idx];
        is_div = (r.op >= OP_DIV);
        bus = '0;
        bus.alu_op = alu_op_t'(19'b1 << (`EXE_ALU_OPS - 1 - r.op));
        bus.res_from_mem = |r.ld_op;
        bus.alu_src1 = r.src1;
        bus.alu_src2 = r.src2;
        // alternate csr_re so the forwarded flag takes both values
        bus.csr_re = idx[0];
        bus.rf_we = 1'b1;
        bus.rf_waddr = idx[4:0];
        bus.rkd_value = STORE_DATA;
        bus.pc = PC_BASE + idx * 4;
        bus.st_op = r.st_op;
        bus.ld_op = r.ld_op;
        bus.rdcntvh = r.rdcntvh;
        bus.rdcntvl = r.rdcntvl;
        bus.exc = r.exc;
        ds2es_valid = 1'b1;
        ds2es_bus = bus;
        @(negedge clk);
        while (!es_allowin) begin
            step_backpressure();
            @(negedge clk);
        end
        // capture edge, then the first valid cycle
        step_backpressure();
        ds2es_valid = 1'b0;
        ms_ex = r.ms_ex;
        wb_ex = r.wb_ex;
        @(negedge clk);
        cyc = 1;
        check(r.name, "sram_en", |{r.st_op, r.ld_op}, data_sram_en);
        check(r.name, "sram_we", r.we, data_sram_we);
        if (|r.st_op) begin
            check(r.name, "sram_wdata", r.wdata, data_sram_wdata);
        end
        if (|{r.st_op, r.ld_op}) begin
            check(r.name, "sram_addr", {r.result[31:2], 2'b00}, data_sram_addr);
        end
        if (!is_div) begin
            check(r.name, "fwd result", expected_result(r), es_fwd.result);
        end
        check(r.name, "fwd rf_we", 1'b1, es_fwd.rf_we);
        check(r.name, "fwd rf_waddr", bus.rf_waddr, es_fwd.rf_waddr);
        check(r.name, "fwd csr_re", bus.csr_re, es_fwd.csr_re);
        check(r.name, "fwd res_from_mem", bus.res_from_mem, es_fwd.res_from_mem);
        if (r.wb_ex) begin
            // single-cycle ops are ready before the flush edge, divisions are not
            check(r.name, "es2ms_valid before flush", !is_div, es2ms_valid);
            step_backpressure();
            @(negedge clk);
            check(r.name, "es2ms_valid after flush", 1'b0, es2ms_valid);
            check(r.name, "es_allowin after flush", 1'b1, es_allowin);
            check(r.name, "fwd rf_we after flush", 1'b0, es_fwd.rf_we);
            step_backpressure();
            return;
        end
        first_rise = 0;
        forever begin
            if (first_rise != 0) begin
                check(r.name, "es2ms_valid held", 1'b1, es2ms_valid);
            end
            if (es2ms_valid) begin
                if (first_rise == 0) begin
                    first_rise = cyc;
                end
                check(r.name, "pc order", bus.pc, es2ms_bus.pc);
                check(r.name, "ale", r.ale, es2ms_bus.ale);
                check(r.name, "ld_op", r.ld_op, es2ms_bus.ld_op);
                check(r.name, "exc", r.exc, es2ms_bus.exc);
                check(r.name, "result", expected_result(r), es_fwd.result);
                if (ms_allowin) begin
                    check(r.name, "es_allowin on delivery", 1'b1, es_allowin);
                    break;
                end
            end
            check(r.name, "es_allowin while busy", 1'b0, es_allowin);
            step_backpressure();
            @(negedge clk);
            cyc++;
        end
        check(r.name, "cycles to es2ms_valid", is_div ? 33 : 1, first_rise);
        // delivery edge
        step_backpressure();
    endtask

    initial begin
        resetn = 1'b0;
        ds2es_valid = 1'b0;
        ds2es_bus = '0;
        ms_allowin = 1'b1;
        ms_ex = 1'b0;
        wb_ex = 1'b0;

        alu_row("add", OP_ADD, 32'd5, 32'd7, 32'd12);
        alu_row("sub", OP_SUB, 32'd3, 32'd5, 32'hfffffffe);
        alu_row("slt", OP_SLT, 32'hffffffff, 32'd1, 32'd1);
        alu_row("sltu", OP_SLTU, 32'hffffffff, 32'd1, 32'd0);
        alu_row("nor", OP_NOR, 32'h0f0f0000, 32'h00f0f0f0, 32'hf0000f0f);
        alu_row("sll", OP_SLL, 32'd1, 32'd33, 32'd2);
        alu_row("sra", OP_SRA, 32'h80000000, 32'd4, 32'hf8000000);
        alu_row("srl", OP_SRL, 32'h80000000, 32'd4, 32'h08000000);
        alu_row("lui", OP_LUI, 32'd0, 32'h12345000, 32'h12345000);
        alu_row("mul", OP_MUL, 32'd7, 32'hfffffffd, 32'hffffffeb);
        alu_row("mulh", OP_MULH, 32'hffffffff, 32'hffffffff, 32'h00000000);
        alu_row("mulhu", OP_MULHU, 32'hffffffff, 32'hffffffff, 32'hfffffffe);
        alu_row("div", OP_DIV, 32'hfffffff9, 32'd2, 32'hfffffffd);
        alu_row("mod", OP_MOD, 32'hfffffff9, 32'd2, 32'hffffffff);
        alu_row("divu", OP_DIVU, 32'd100, 32'd7, 32'd14);
        alu_row("modu", OP_MODU, 32'd100, 32'd7, 32'd2);
        alu_row("div by zero", OP_DIV, 32'h1234, 32'd0, 32'hffffffff);
        alu_row("mod by zero", OP_MOD, 32'h1234, 32'd0, 32'h1234);

        // stores at every offset, store data a1b2c3d4
        store_row("st_b off0", 3'b100, 32'h1000, 4'b0001, 32'hd4d4d4d4, 1'b0);
        store_row("st_b off1", 3'b100, 32'h1001, 4'b0010, 32'hd4d4d4d4, 1'b0);
        store_row("st_b off2", 3'b100, 32'h1002, 4'b0100, 32'hd4d4d4d4, 1'b0);
        store_row("st_b off3", 3'b100, 32'h1003, 4'b1000, 32'hd4d4d4d4, 1'b0);
        store_row("st_h off0", 3'b010, 32'h1000, 4'b0011, 32'hc3d4c3d4, 1'b0);
        store_row("st_h off1", 3'b010, 32'h1001, 4'b0000, 32'hc3d4c3d4, 1'b1);
        store_row("st_h off2", 3'b010, 32'h1002, 4'b1100, 32'hc3d4c3d4, 1'b0);
        store_row("st_h off3", 3'b010, 32'h1003, 4'b0000, 32'hc3d4c3d4, 1'b1);
        store_row("st_w off0", 3'b001, 32'h1000, 4'b1111, 32'ha1b2c3d4, 1'b0);
        store_row("st_w off1", 3'b001, 32'h1001, 4'b0000, 32'ha1b2c3d4, 1'b1);
        store_row("st_w off2", 3'b001, 32'h1002, 4'b0000, 32'ha1b2c3d4, 1'b1);
        store_row("st_w off3", 3'b001, 32'h1003, 4'b0000, 32'ha1b2c3d4, 1'b1);

        r = blank_row("ld_w", OP_ADD, 32'h2000, 32'h4, 32'h2004);
        r.ld_op = 5'b00001;
        rows.push_back(r);
        r = blank_row("ld_h misaligned", OP_ADD, 32'h2000, 32'h1, 32'h2001);
        r.ld_op = 5'b00100;
        r.ale = 1'b1;
        rows.push_back(r);

        // flushes keep the write strobe at zero
        r = store_entry("st_w ms_ex", 3'b001, 32'h3000, 4'b0000, 32'ha1b2c3d4, 1'b0);
        r.ms_ex = 1'b1;
        rows.push_back(r);
        r = store_entry("st_w exc", 3'b001, 32'h3004, 4'b0000, 32'ha1b2c3d4, 1'b0);
        r.exc = 6'h01;
        rows.push_back(r);
        r = store_entry("st_w wb_ex", 3'b001, 32'h3008, 4'b0000, 32'ha1b2c3d4, 1'b0);
        r.wb_ex = 1'b1;
        rows.push_back(r);
        r = blank_row("divu wb_ex", OP_DIVU, 32'd100, 32'd7, 32'd14);
        r.wb_ex = 1'b1;
        rows.push_back(r);
        alu_row("add after flush", OP_ADD, 32'h10, 32'h20, 32'h30);

        // operands give a nonzero ALU sum so a missed select shows up
        r = blank_row("rdcntvl", OP_ADD, 32'h11, 32'h22, 32'h33);
        r.rdcntvl = 1'b1;
        rows.push_back(r);
        r = blank_row("rdcntvh", OP_ADD, 32'h55, 32'h22, 32'h77);
        r.rdcntvh = 1'b1;
        rows.push_back(r);

        cycle_limit = rows.size() * `TB_CYCLES_PER_ROW + `TB_CYCLE_SLACK;

        repeat (`TB_RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b1;
        release_cycle = cycle_count;
        @(negedge clk);
        check("reset", "es2ms_valid", 1'b0, es2ms_valid);
        check("reset", "sram_en", 1'b0, data_sram_en);
        check("reset", "sram_we", 4'b0000, data_sram_we);
        check("reset", "fwd rf_we", 1'b0, es_fwd.rf_we);
        check("reset", "fwd csr_re", 1'b0, es_fwd.csr_re);
        check("reset", "fwd res_from_mem", 1'b0, es_fwd.res_from_mem);
        step_backpressure();

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

//--- logic/exe_stage.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   ds2es_valid,
    input  exe_pkg::ds2es_bus_t    ds2es_bus,
    output logic                   es_allowin,
    input  logic                   ms_allowin,
    output logic                   es2ms_valid,
    output exe_pkg::es2ms_bus_t    es2ms_bus,
    output exe_pkg::es_fwd_t       es_fwd,
    output logic                   data_sram_en,
    output logic [`EXE_XLEN/8-1:0] data_sram_we,
    output exe_pkg::word_t         data_sram_addr,
    output exe_pkg::word_t         data_sram_wdata,
    input  logic                   ms_ex,
    input  logic                   wb_ex
);
    import exe_pkg::*;

    ds2es_bus_t               es_bus;
    logic                     es_valid;
    logic                     es_first;
    logic                     es_ready_go;
    logic                     es_load;
    logic                     es_kill;
    logic                     es_ale;
    word_t                    alu_result;
    word_t                    es_result;
    logic [2*`EXE_XLEN-1:0]   stable_cnt;

    assign es_load     = ds2es_valid & es_allowin;
    assign es_allowin  = ~es_valid | (es_ready_go & ms_allowin);
    assign es2ms_valid = es_valid & es_ready_go;

    // a flush from writeback wins over a new capture
    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (wb_ex) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds2es_valid;
        end
    end

    // marks the first valid cycle of each instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_first <= 1'b0;
        end else begin
            es_first <= es_load & ~wb_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (es_load) begin
            es_bus <= ds2es_bus;
        end
    end

    // free-running 64-bit counter for rdcntvl/rdcntvh
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    exe_alu i_exe_alu (
        .clk        (clk),
        .resetn     (resetn),
        .op_valid   (es_valid),
        .op_new     (es_first),
        .alu_op     (es_bus.alu_op),
        .alu_src1   (es_bus.alu_src1),
        .alu_src2   (es_bus.alu_src2),
        .alu_result (alu_result),
        .complete   (es_ready_go)
    );

    // later exceptions or one already on this instruction block the store
    assign es_kill = ms_ex | wb_ex | (|es_bus.exc);

    exe_mem_req i_exe_mem_req (
        .mem_valid    (es_valid),
        .res_from_mem (es_bus.res_from_mem),
        .st_op        (es_bus.st_op),
        .ld_op        (es_bus.ld_op),
        .addr         (alu_result),
        .store_data   (es_bus.rkd_value),
        .kill         (es_kill),
        .ale          (es_ale),
        .sram_en      (data_sram_en),
        .sram_we      (data_sram_we),
        .sram_addr    (data_sram_addr),
        .sram_wdata   (data_sram_wdata)
    );

    assign es_result = es_bus.rdcntvh ? stable_cnt[2*`EXE_XLEN-1:`EXE_XLEN] :
                       es_bus.rdcntvl ? stable_cnt[`EXE_XLEN-1:0] : alu_result;

    assign es2ms_bus.ld_op = es_bus.ld_op;
    assign es2ms_bus.pc    = es_bus.pc;
    assign es2ms_bus.exc   = es_bus.exc;
    assign es2ms_bus.ale   = es_ale;

    // decode only sees the flags while this stage holds something
    assign es_fwd.csr_re       = es_bus.csr_re & es_valid;
    assign es_fwd.res_from_mem = es_bus.res_from_mem & es_valid;
    assign es_fwd.rf_we        = es_bus.rf_we & es_valid;
    assign es_fwd.rf_waddr     = es_bus.rf_waddr;
    assign es_fwd.result       = es_result;

endmodule

//--- logic/exe_mem_req.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_mem_req (
    input  logic                      mem_valid,
    input  logic                      res_from_mem,
    input  exe_pkg::st_op_t           st_op,
    input  exe_pkg::ld_op_t           ld_op,
    input  exe_pkg::word_t            addr,
    input  exe_pkg::word_t            store_data,
    input  logic                      kill,
    output logic                      ale,
    output logic                      sram_en,
    output logic [`EXE_XLEN/8-1:0]    sram_we,
    output exe_pkg::word_t            sram_addr,
    output exe_pkg::word_t            sram_wdata
);
    import exe_pkg::*;

    logic [`EXE_XLEN/8-1:0] byte_en;
    logic                   word_acc;
    logic                   half_acc;

    assign word_acc = st_op.st_w | ld_op.ld_w;
    assign half_acc = st_op.st_h | ld_op.ld_h | ld_op.ld_hu;

    // word needs both low bits clear, halfword only bit 0
    assign ale = mem_valid & ((word_acc & (|addr[1:0])) | (half_acc & addr[0]));

    // lane enables from store width and address offset
    always_comb begin
        byte_en = '0;
        if (st_op.st_w) begin
            byte_en = 4'b1111;
        end else if (st_op.st_h) begin
            byte_en = addr[1] ? 4'b1100 : 4'b0011;
        end else if (st_op.st_b) begin
            byte_en = 4'b0001 << addr[1:0];
        end
    end

    // narrow stores land in every lane, byte enables pick the right one
    assign sram_wdata = st_op.st_b ? {4{store_data[7:0]}}  :
                        st_op.st_h ? {2{store_data[15:0]}} : store_data;

    assign sram_en   = mem_valid & (res_from_mem | (|st_op));
    assign sram_we   = (mem_valid & ~kill & ~ale) ? byte_en : '0;
    assign sram_addr = {addr[`EXE_XLEN-1:2], 2'b00};

endmodule

//--- logic/exe_alu.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_alu (
    input  logic             clk,
    input  logic             resetn,
    input  logic             op_valid,
    input  logic             op_new,
    input  exe_pkg::alu_op_t alu_op,
    input  exe_pkg::word_t   alu_src1,
    input  exe_pkg::word_t   alu_src2,
    output exe_pkg::word_t   alu_result,
    output logic             complete
);
    import exe_pkg::*;

    localparam int SH_W = $clog2(`EXE_XLEN);

    logic [`EXE_ALU_OPS-1:0]               op_sel;
    logic [`EXE_ALU_OPS-1:0][`EXE_XLEN-1:0] op_res;
    logic [SH_W-1:0]                       shamt;
    word_t                                 add_res;
    word_t                                 sub_res;
    logic signed [`EXE_XLEN:0]             mul_a;
    logic signed [`EXE_XLEN:0]             mul_b;
    logic signed [2*`EXE_XLEN+1:0]         mul_prod;
    logic                                  is_div;
    logic                                  div_signed;
    logic                                  div_start;
    logic                                  div_cancel;
    logic                                  div_busy;
    logic                                  div_done;
    logic                                  div_held;
    word_t                                 div_quo;
    word_t                                 div_rem;
    word_t                                 div_now;
    word_t                                 div_res_q;
    word_t                                 div_out;

    assign op_sel = alu_op;
    assign shamt  = alu_src2[SH_W-1:0];

    assign add_res = alu_src1 + alu_src2;
    assign sub_res = alu_src1 - alu_src2;

    // one extra bit so a single signed multiplier covers mulh and mulhu
    assign mul_a    = {alu_op.op_mulh & alu_src1[`EXE_XLEN-1], alu_src1};
    assign mul_b    = {alu_op.op_mulh & alu_src2[`EXE_XLEN-1], alu_src2};
    assign mul_prod = mul_a * mul_b;

    assign is_div     = alu_op.op_div | alu_op.op_mod | alu_op.op_divu | alu_op.op_modu;
    assign div_signed = alu_op.op_div | alu_op.op_mod;
    assign div_start  = op_valid & op_new & is_div;
    // abandon a running division once the instruction is gone
    assign div_cancel = div_busy & ~op_valid;

    exe_divider i_exe_divider (
        .clk       (clk),
        .resetn    (resetn),
        .start     (div_start),
        .cancel    (div_cancel),
        .is_signed (div_signed),
        .dividend  (alu_src1),
        .divisor   (alu_src2),
        .quotient  (div_quo),
        .remainder (div_rem),
        .busy      (div_busy),
        .done      (div_done)
    );

    assign div_now = (alu_op.op_div | alu_op.op_divu) ? div_quo : div_rem;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_held <= 1'b0;
        end else if (!op_valid || op_new) begin
            div_held <= 1'b0;
        end else if (div_done) begin
            div_held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (div_done) begin
            div_res_q <= div_now;
        end
    end

    assign div_out = div_done ? div_now : div_res_q;

    // a held result belongs to the previous instruction until op_new clears it
    assign complete = ~is_div | div_done | (div_held & ~op_new);

    // same order as the fields of alu_op_t
    assign op_res = {
        add_res,
        sub_res,
        word_t'($signed(alu_src1) < $signed(alu_src2)),
        word_t'(alu_src1 < alu_src2),
        alu_src1 & alu_src2,
        alu_src1 | alu_src2,
        ~(alu_src1 | alu_src2),
        alu_src1 ^ alu_src2,
        alu_src1 << shamt,
        alu_src1 >> shamt,
        word_t'($signed(alu_src1) >>> shamt),
        alu_src2,
        mul_prod[`EXE_XLEN-1:0],
        mul_prod[2*`EXE_XLEN-1:`EXE_XLEN],
        mul_prod[2*`EXE_XLEN-1:`EXE_XLEN],
        div_out,
        div_out,
        div_out,
        div_out
    };

    always_comb begin
        alu_result = '0;
        for (int i = 0; i < `EXE_ALU_OPS; i++) begin
            alu_result = alu_result | (op_res[i] & {`EXE_XLEN{op_sel[i]}});
        end
    end

endmodule

//--- logic/exe_divider.sv
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_divider (
    input  logic           clk,
    input  logic           resetn,
    input  logic           start,
    input  logic           cancel,
    input  logic           is_signed,
    input  exe_pkg::word_t dividend,
    input  exe_pkg::word_t divisor,
    output exe_pkg::word_t quotient,
    output exe_pkg::word_t remainder,
    output logic           busy,
    output logic           done
);
    import exe_pkg::*;

    localparam int CNT_W = $clog2(`EXE_DIV_ITERS);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(`EXE_DIV_ITERS - 1);

    word_t              dividend_mag;
    word_t              divisor_mag;
    word_t              quo_q;
    word_t              rem_q;
    word_t              dsr_q;
    word_t              quo_next;
    word_t              rem_next;
    logic [`EXE_XLEN:0] trial;
    logic [CNT_W-1:0]   iter_cnt;
    logic               neg_quo;
    logic               neg_rem;
    logic               by_zero;

    // work on magnitudes, fix signs at the end
    assign dividend_mag = (is_signed && dividend[`EXE_XLEN-1]) ? -dividend : dividend;
    assign divisor_mag  = (is_signed && divisor[`EXE_XLEN-1]) ? -divisor : divisor;

    // shift next dividend bit into the partial remainder, try the subtract
    assign trial    = {rem_q, quo_q[`EXE_XLEN-1]} - {1'b0, dsr_q};
    assign rem_next = trial[`EXE_XLEN] ? {rem_q[`EXE_XLEN-2:0], quo_q[`EXE_XLEN-1]}
                                       : trial[`EXE_XLEN-1:0];
    assign quo_next = {quo_q[`EXE_XLEN-2:0], ~trial[`EXE_XLEN]};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            iter_cnt <= '0;
        end else if (cancel) begin
            busy <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            iter_cnt <= '0;
        end else if (busy) begin
            iter_cnt <= iter_cnt + 1'b1;
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_q   <= dividend_mag;
            rem_q   <= '0;
            dsr_q   <= divisor_mag;
            neg_quo <= is_signed & (dividend[`EXE_XLEN-1] ^ divisor[`EXE_XLEN-1]);
            neg_rem <= is_signed & dividend[`EXE_XLEN-1];
            by_zero <= (divisor == '0);
        end else if (busy) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
        end
    end

    // results come straight off the last step, valid while done is high
    assign done = busy & (iter_cnt == LAST_ITER);

    // remainder keeps the dividend sign, so x / 0 leaves x here
    assign quotient  = by_zero ? '1 : (neg_quo ? -quo_next : quo_next);
    assign remainder = neg_rem ? -rem_next : rem_next;

endmodule

//--- logic/exe_pkg.sv
`include "exe_consts.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0] word_t;

    // field order sets the bit order, op_add is the msb
    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_slt;
        logic op_sltu;
        logic op_and;
        logic op_or;
        logic op_nor;
        logic op_xor;
        logic op_sll;
        logic op_srl;
        logic op_sra;
        logic op_lui;
        logic op_mul;
        logic op_mulh;
        logic op_mulhu;
        logic op_div;
        logic op_mod;
        logic op_divu;
        logic op_modu;
    } alu_op_t;

    typedef struct packed {
        logic st_b;
        logic st_h;
        logic st_w;
    } st_op_t;

    typedef struct packed {
        logic ld_b;
        logic ld_bu;
        logic ld_h;
        logic ld_hu;
        logic ld_w;
    } ld_op_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic                  res_from_mem;
        word_t                 alu_src1;
        word_t                 alu_src2;
        logic                  csr_re;
        logic                  rf_we;
        logic [4:0]            rf_waddr;
        word_t                 rkd_value;
        word_t                 pc;
        st_op_t                st_op;
        ld_op_t                ld_op;
        logic                  rdcntvh;
        logic                  rdcntvl;
        logic [`EXE_EXC_W-1:0] exc;
    } ds2es_bus_t;

    typedef struct packed {
        ld_op_t                ld_op;
        word_t                 pc;
        logic [`EXE_EXC_W-1:0] exc;
        logic                  ale;
    } es2ms_bus_t;

    typedef struct packed {
        logic       csr_re;
        logic       res_from_mem;
        logic       rf_we;
        logic [4:0] rf_waddr;
        word_t      result;
    } es_fwd_t;

endpackage

//--- include/exe_consts.svh
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// data path and address width
`define EXE_XLEN 32

// one-hot ALU operation count
`define EXE_ALU_OPS 19

// exception code vector carried down the pipe
`define EXE_EXC_W 6

// shift-subtract cycles per division, one per quotient bit
`define EXE_DIV_ITERS 32

`endif
